//--- rtl/nec_ir_pkg.sv
// NEC IR receiver package
// Widths, nominal pulse lengths in sample ticks, tolerance settings,
// decoder states and the decoded frame record

package nec_ir_pkg;

  localparam int SYNC_STAGES = 3;  // Input synchronizer depth
  localparam int TICK_W      = 16; // Tick divider width
  localparam int DELAY_W     = 11; // Pulse counter width, all-ones is timeout

  typedef logic [DELAY_W-1:0] delay_t;

  ////////////////////
  // Nominal pulse lengths in ticks
  localparam delay_t LEN_LEADER_MARK  = delay_t'(128); // 9 ms
  localparam delay_t LEN_LEADER_SPACE = delay_t'(64);  // 4.5 ms
  localparam delay_t LEN_REPEAT_SPACE = delay_t'(32);  // 2.25 ms
  localparam delay_t LEN_BIT_MARK     = delay_t'(8);
  localparam delay_t LEN_ZERO_SPACE   = delay_t'(8);
  localparam delay_t LEN_ONE_SPACE    = delay_t'(24);

  // Shift register seed, the marker bit reaches bit 0 after 31 bits
  localparam logic [31:0] SHIFT_SEED = 32'h8000_0000;

  ////////////////////
  typedef enum logic [1:0] {
    TOL_TIGHT  = 2'd0, // Offset 1, mask bit 0
    TOL_NORMAL = 2'd1, // Offset 2, mask bits 1:0
    TOL_WIDE   = 2'd2  // Offset 4, mask bits 2:0
  } tolerance_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LEADER,
    ST_BIT_MARK,
    ST_BIT_SPACE,
    ST_STOP
  } decoder_state_e;

  typedef struct packed {
    logic       repeat_flag;
    logic [7:0] addr;
    logic [7:0] data;
  } frame_t;

endpackage

//--- rtl/ir_event_if.sv
// Pulse event bus
// One measured level change from the edge timer to the frame decoder

interface ir_event_if;

  logic                evt_new;     // One-cycle event strobe
  logic                evt_level;   // 1 rising, 0 falling
  nec_ir_pkg::delay_t  evt_delay;   // Pulse length plus reload offset
  logic                evt_timeout; // Counter had saturated

  modport source (
    output evt_new,
    output evt_level,
    output evt_delay,
    output evt_timeout
  );

  modport sink (
    input evt_new,
    input evt_level,
    input evt_delay,
    input evt_timeout
  );

endinterface

//--- rtl/ir_sampler.sv
// IR line sampler
// Synchronizes the raw line, applies polarity, generates the sample tick
// and filters each sample with a three-tap majority vote

module ir_sampler (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          ir_i,
  input  logic                          receiver_en_i,
  input  logic                          polarity_i,
  input  logic [nec_ir_pkg::TICK_W-1:0] tick_div_i,
  output logic                          sample_o,
  output logic                          sample_valid_o
);

  logic [nec_ir_pkg::SYNC_STAGES-1:0] sync_q;
  logic [nec_ir_pkg::TICK_W-1:0]      tick_cnt_q;
  logic [2:0]                         hist_q;
  logic                               line_lvl;
  logic                               tick;

  ////////////////////
  // Synchronizer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[nec_ir_pkg::SYNC_STAGES-2:0], ir_i};
    end
  end

  assign line_lvl = sync_q[nec_ir_pkg::SYNC_STAGES-1] ^ polarity_i; // Inverted when set

  ////////////////////
  // Tick generator
  assign tick = (tick_cnt_q == '0);

  always_ff @(posedge clk) begin
    if (!rst_n || !receiver_en_i) begin
      tick_cnt_q <= '0;
    end else if (tick) begin
      tick_cnt_q <= tick_div_i; // Reload for next period
    end else begin
      tick_cnt_q <= tick_cnt_q - 1'b1;
    end
  end

  ////////////////////
  // Majority filter
  always_ff @(posedge clk) begin
    if (!rst_n || !receiver_en_i) begin
      hist_q         <= '0;
      sample_valid_o <= 1'b0;
    end else begin
      sample_valid_o <= tick;
      if (tick) begin
        hist_q <= {line_lvl, hist_q[2:1]}; // Newest sample on top
      end
    end
  end

  // Two of three samples win
  assign sample_o = (hist_q[0] & hist_q[1]) |
                    (hist_q[1] & hist_q[2]) |
                    (hist_q[2] & hist_q[0]);

endmodule

//--- rtl/edge_timer.sv
// Edge timer
// Counts ticks between level changes of the filtered samples and reports
// every change with its pulse length and a saturation flag

module edge_timer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   receiver_en_i,
  input  nec_ir_pkg::tolerance_e tolerance_i,
  input  logic                   sample_i,
  input  logic                   sample_valid_i,
  ir_event_if.source             evt
);

  nec_ir_pkg::delay_t reload_offset;
  nec_ir_pkg::delay_t cnt_q;
  nec_ir_pkg::delay_t cnt_inc;
  logic               last_q;
  logic               change;
  logic               full;

  // Start offset widens the accepted window
  always_comb begin
    case (tolerance_i)
      nec_ir_pkg::TOL_TIGHT:  reload_offset = nec_ir_pkg::delay_t'(1);
      nec_ir_pkg::TOL_NORMAL: reload_offset = nec_ir_pkg::delay_t'(2);
      default:                reload_offset = nec_ir_pkg::delay_t'(4); // Wide and code 3
    endcase
  end

  assign change  = (sample_i != last_q);
  assign full    = (cnt_q == '1);
  assign cnt_inc = cnt_q + 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n || !receiver_en_i) begin
      last_q      <= 1'b0;
      cnt_q       <= '1; // Start as timed out
      evt.evt_new <= 1'b0;
    end else begin
      evt.evt_new <= sample_valid_i && change;
      if (sample_valid_i) begin
        last_q <= sample_i;
        if (change) begin
          cnt_q <= reload_offset;
        end else if (!full) begin
          cnt_q <= cnt_inc; // Saturates at all-ones
        end
      end
    end
  end

  // Event payload
  always_ff @(posedge clk) begin
    if (sample_valid_i && change) begin
      evt.evt_level   <= sample_i;
      evt.evt_delay   <= cnt_inc;
      evt.evt_timeout <= full;
    end
  end

endmodule

//--- rtl/nec_frame_decoder.sv
// NEC frame decoder
// Walks leader, 32 data bits and stop mark from the pulse events,
// checks the bytes against their complements and tracks repeat codes.
// Marks end on a falling change and spaces on a rising change

module nec_frame_decoder (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   receiver_en_i,
  input  logic                   repeat_en_i,
  input  nec_ir_pkg::tolerance_e tolerance_i,
  ir_event_if.sink               evt,
  output logic                   frame_valid_o,
  output nec_ir_pkg::frame_t     frame_o
);

  nec_ir_pkg::decoder_state_e state_q;
  nec_ir_pkg::delay_t         delay_mask;
  nec_ir_pkg::delay_t         delay_m;
  logic [31:0]                shift_q;
  logic                       repeat_q;      // Current frame is a repeat code
  logic                       frame_seen_q;  // Good frame since timeout
  logic                       mark_end;
  logic                       space_end;
  logic                       leader_mark_ok;
  logic                       leader_space_ok;
  logic                       repeat_space_ok;
  logic                       bit_mark_ok;
  logic                       zero_space_ok;
  logic                       one_space_ok;
  logic                       addr_ok;
  logic                       data_ok;
  logic                       emit;

  // Low bits ignored in comparisons
  always_comb begin
    case (tolerance_i)
      nec_ir_pkg::TOL_TIGHT:  delay_mask = ~nec_ir_pkg::delay_t'(1);
      nec_ir_pkg::TOL_NORMAL: delay_mask = ~nec_ir_pkg::delay_t'(3);
      default:                delay_mask = ~nec_ir_pkg::delay_t'(7);
    endcase
  end

  ////////////////////
  // Pulse classification
  assign delay_m   = evt.evt_delay & delay_mask;
  assign mark_end  = !evt.evt_timeout && !evt.evt_level;
  assign space_end = !evt.evt_timeout && evt.evt_level;

  assign leader_mark_ok  = mark_end  && (delay_m == nec_ir_pkg::LEN_LEADER_MARK);
  assign leader_space_ok = space_end && (delay_m == nec_ir_pkg::LEN_LEADER_SPACE);
  assign repeat_space_ok = space_end && (delay_m == nec_ir_pkg::LEN_REPEAT_SPACE);
  assign bit_mark_ok     = mark_end  && (delay_m == nec_ir_pkg::LEN_BIT_MARK);
  assign zero_space_ok   = space_end && (delay_m == nec_ir_pkg::LEN_ZERO_SPACE);
  assign one_space_ok    = space_end && (delay_m == nec_ir_pkg::LEN_ONE_SPACE);

  assign addr_ok = (shift_q[7:0]   == ~shift_q[15:8]);
  assign data_ok = (shift_q[23:16] == ~shift_q[31:24]);

  // Stop mark closes a good frame or an accepted repeat
  assign emit = receiver_en_i && evt.evt_new && (state_q == nec_ir_pkg::ST_STOP) &&
                bit_mark_ok && (repeat_q || (addr_ok && data_ok));

  ////////////////////
  // Protocol FSM
  always_ff @(posedge clk) begin
    if (!rst_n || !receiver_en_i) begin
      state_q       <= nec_ir_pkg::ST_IDLE;
      repeat_q      <= 1'b0;
      frame_seen_q  <= 1'b0;
      frame_valid_o <= 1'b0;
    end else begin
      frame_valid_o <= emit;
      if (evt.evt_new) begin
        case (state_q)
          nec_ir_pkg::ST_IDLE: begin
            if (leader_mark_ok) begin
              state_q <= nec_ir_pkg::ST_LEADER;
            end
          end
          nec_ir_pkg::ST_LEADER: begin
            repeat_q <= 1'b0;
            if (leader_space_ok) begin
              state_q <= nec_ir_pkg::ST_BIT_MARK;
            end else if (repeat_en_i && repeat_space_ok && frame_seen_q) begin
              state_q  <= nec_ir_pkg::ST_STOP; // Repeat code skips the data bits
              repeat_q <= 1'b1;
            end else begin
              state_q <= nec_ir_pkg::ST_IDLE;
            end
          end
          nec_ir_pkg::ST_BIT_MARK: begin
            state_q <= bit_mark_ok ? nec_ir_pkg::ST_BIT_SPACE : nec_ir_pkg::ST_IDLE;
          end
          nec_ir_pkg::ST_BIT_SPACE: begin
            if (!(zero_space_ok || one_space_ok)) begin
              state_q <= nec_ir_pkg::ST_IDLE;
            end else if (shift_q[0]) begin
              state_q <= nec_ir_pkg::ST_STOP; // Marker shifts out with bit 32
            end else begin
              state_q <= nec_ir_pkg::ST_BIT_MARK;
            end
          end
          default: begin
            state_q <= nec_ir_pkg::ST_IDLE;
          end
        endcase

        if (evt.evt_timeout) begin
          frame_seen_q <= 1'b0; // Line idled too long
        end else if (emit && !repeat_q) begin
          frame_seen_q <= 1'b1;
        end
      end
    end
  end

  ////////////////////
  // Data path
  always_ff @(posedge clk) begin
    if (evt.evt_new) begin
      if ((state_q == nec_ir_pkg::ST_LEADER) && leader_space_ok) begin
        shift_q <= nec_ir_pkg::SHIFT_SEED;
      end else if ((state_q == nec_ir_pkg::ST_BIT_SPACE) && (zero_space_ok || one_space_ok)) begin
        shift_q <= {one_space_ok, shift_q[31:1]}; // LSB first
      end
    end
    if (emit) begin
      frame_o.repeat_flag <= repeat_q;
      if (!repeat_q) begin
        frame_o.addr <= shift_q[7:0];
        frame_o.data <= shift_q[23:16];
      end
    end
  end

endmodule

//--- rtl/nec_ir_receiver.sv
// NEC infrared receiver top level
// Sampler, edge timer and frame decoder in series, with the decoded
// frame split into plain output ports

module nec_ir_receiver (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          ir_i,
  input  logic                          receiver_en_i,
  input  logic                          repeat_en_i,
  input  logic                          polarity_i,
  input  nec_ir_pkg::tolerance_e        tolerance_i,
  input  logic [nec_ir_pkg::TICK_W-1:0] tick_div_i,
  output logic                          frame_valid_o,
  output logic [7:0]                    frame_addr_o,
  output logic [7:0]                    frame_data_o,
  output logic                          frame_repeat_o
);

  logic               sample;
  logic               sample_valid;
  nec_ir_pkg::frame_t frame;

  ir_event_if evt_bus ();

  ir_sampler u_sampler (
    .clk            (clk),
    .rst_n          (rst_n),
    .ir_i           (ir_i),
    .receiver_en_i  (receiver_en_i),
    .polarity_i     (polarity_i),
    .tick_div_i     (tick_div_i),
    .sample_o       (sample),
    .sample_valid_o (sample_valid)
  );

  edge_timer u_edge_timer (
    .clk            (clk),
    .rst_n          (rst_n),
    .receiver_en_i  (receiver_en_i),
    .tolerance_i    (tolerance_i),
    .sample_i       (sample),
    .sample_valid_i (sample_valid),
    .evt            (evt_bus.source)
  );

  nec_frame_decoder u_decoder (
    .clk           (clk),
    .rst_n         (rst_n),
    .receiver_en_i (receiver_en_i),
    .repeat_en_i   (repeat_en_i),
    .tolerance_i   (tolerance_i),
    .evt           (evt_bus.sink),
    .frame_valid_o (frame_valid_o),
    .frame_o       (frame)
  );

  assign frame_addr_o   = frame.addr;
  assign frame_data_o   = frame.data;
  assign frame_repeat_o = frame.repeat_flag;

endmodule

//--- verification/nec_ir_tx_model.sv
// NEC IR transmitter model
// Plays a frame or a repeat code on the IR line, timed in sample ticks,
// with optional line inversion and extra length on every space

module nec_ir_tx_model (
  input  logic                          clk,
  input  logic                          invert_i,
  input  logic [nec_ir_pkg::TICK_W-1:0] tick_div_i,
  output logic                          ir_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic mark_lvl; // Line carries a mark

  assign ir_o = mark_lvl ^ invert_i; // Inverted line when set

  // Idle line is a space
  task automatic set_idle();
    mark_lvl = 1'b0;
  endtask

  // Hold a mark or space for a whole number of ticks
  task automatic hold_level(input logic mark, input int ticks);
    mark_lvl = mark;
    repeat (ticks * (int'(tick_div_i) + 1)) begin
      @(posedge clk);
    end
    #2;
  endtask

  ////////////////////
  // Kind 0 plays a full frame and any other kind a repeat code
  task automatic send_frame(input int kind, input int gap, input logic [31:0] bits,
                            input int jitter);
    hold_level(1'b0, gap);
    hold_level(1'b1, int'(nec_ir_pkg::LEN_LEADER_MARK));
    if (kind == 0) begin
      hold_level(1'b0, int'(nec_ir_pkg::LEN_LEADER_SPACE) + jitter);
      for (int i = 0; i < 32; i++) begin // LSB of the address goes first
        hold_level(1'b1, int'(nec_ir_pkg::LEN_BIT_MARK));
        if (bits[i]) begin
          hold_level(1'b0, int'(nec_ir_pkg::LEN_ONE_SPACE) + jitter);
        end else begin
          hold_level(1'b0, int'(nec_ir_pkg::LEN_ZERO_SPACE) + jitter);
        end
      end
    end else begin
      hold_level(1'b0, int'(nec_ir_pkg::LEN_REPEAT_SPACE) + jitter);
    end
    hold_level(1'b1, int'(nec_ir_pkg::LEN_BIT_MARK)); // Stop mark
    set_idle();
  endtask

endmodule

//--- verification/tb_nec_ir_receiver.sv
// Testbench for the NEC IR receiver
// Plays each line of the test file through the transmitter model and
// checks the frame strobe, the bytes and the repeat flag

module tb_nec_ir_receiver;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [nec_ir_pkg::TICK_W-1:0] TICK_DIV = 3;
  localparam int CLK_PER_TICK = 4;    // TICK_DIV plus one
  localparam int GAP_SHORT    = 100;  // Idle ticks before a frame
  localparam int GAP_LONG     = 2100; // Past counter saturation
  localparam int WAIT_TICKS   = 64;   // Strobe window after the stop mark
  localparam int GUARD_TICKS  = 16;

  logic                          clk = 1'b0;
  logic                          rst_n;
  logic                          ir;
  logic                          receiver_en;
  logic                          repeat_en;
  logic                          polarity;
  nec_ir_pkg::tolerance_e        tolerance;
  logic [nec_ir_pkg::TICK_W-1:0] tick_div;
  logic                          frame_valid;
  logic [7:0]                    frame_addr;
  logic [7:0]                    frame_data;
  logic                          frame_repeat;

  int                 strobe_cnt = 0;
  nec_ir_pkg::frame_t last_frame;
  int                 test_no;
  int                 pol_v, rep_v, tol_v, kind_v, jitter_v, exp_strobe_v, exp_repeat_v;
  logic [7:0]         addr_v, addr_n_v, data_v, data_n_v, exp_addr_v, exp_data_v;

  nec_ir_receiver uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .ir_i           (ir),
    .receiver_en_i  (receiver_en),
    .repeat_en_i    (repeat_en),
    .polarity_i     (polarity),
    .tolerance_i    (tolerance),
    .tick_div_i     (tick_div),
    .frame_valid_o  (frame_valid),
    .frame_addr_o   (frame_addr),
    .frame_data_o   (frame_data),
    .frame_repeat_o (frame_repeat)
  );

  nec_ir_tx_model u_tx (
    .clk        (clk),
    .invert_i   (polarity),
    .tick_div_i (tick_div),
    .ir_o       (ir)
  );

  always #20 clk = ~clk;

  // Count strobes and keep the last frame
  always @(posedge clk) begin
    if (frame_valid) begin
      strobe_cnt = strobe_cnt + 1;
      last_frame = {frame_repeat, frame_addr, frame_data};
    end
  end

  ////////////////////
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic abort_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_strobe(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      $display("mismatch %s in test %0d: got %h, expected %h", name, test_no, got, exp);
      abort_run();
    end
  endtask

  task automatic check_frame(input string name, input nec_ir_pkg::frame_t got,
                             input nec_ir_pkg::frame_t exp);
    if (got !== exp) begin
      $display("mismatch %s in test %0d: got %h, expected %h", name, test_no, got, exp);
      abort_run();
    end
  endtask

  ////////////////////
  task automatic run_test();
    int                 base;
    int                 waited;
    nec_ir_pkg::frame_t exp_frame;
    polarity  = pol_v[0];
    repeat_en = rep_v[0];
    tolerance = nec_ir_pkg::tolerance_e'(tol_v[1:0]);
    base      = strobe_cnt;
    waited    = 0;
    u_tx.send_frame(kind_v, (kind_v == 2) ? GAP_LONG : GAP_SHORT,
                    {data_n_v, data_v, addr_n_v, addr_v}, jitter_v);
    while ((strobe_cnt == base) && (waited < WAIT_TICKS * CLK_PER_TICK)) begin
      next_cycle();
      waited++;
    end
    if ((exp_strobe_v != 0) && (strobe_cnt == base)) begin
      $display("no frame strobe within %0d ticks of the stop mark in test %0d",
               WAIT_TICKS, test_no);
      abort_run();
    end
    check_strobe("frame_valid_o", strobe_cnt != base, exp_strobe_v != 0);
    if (exp_strobe_v != 0) begin
      waited = 0;
      while (waited < GUARD_TICKS * CLK_PER_TICK) begin // A second strobe would land here
        next_cycle();
        waited++;
      end
      check_strobe("frame_valid_o single strobe", (strobe_cnt - base) == 1, 1'b1);
      exp_frame = {exp_repeat_v[0], exp_addr_v, exp_data_v};
      check_frame("frame_repeat_o/frame_addr_o/frame_data_o", last_frame, exp_frame);
    end
  endtask

  initial begin
    string line;
    int    fd;
    int    n;
    rst_n       = 1'b0;
    receiver_en = 1'b1;
    repeat_en   = 1'b1;
    polarity    = 1'b0;
    tolerance   = nec_ir_pkg::TOL_NORMAL;
    tick_div    = TICK_DIV;
    test_no     = 0;
    u_tx.set_idle();
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    fd = $fopen("verification/nec_ir_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open verification/nec_ir_tests.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if ((n > 1) && (line[0] != "#")) begin
        n = $sscanf(line, "%d %d %d %d %h %h %h %h %d %d %d %h %h", pol_v, rep_v, tol_v,
                    kind_v, addr_v, addr_n_v, data_v, data_n_v, jitter_v, exp_strobe_v,
                    exp_repeat_v, exp_addr_v, exp_data_v);
        if (n != 13) begin
          $display("test file entry %0d is malformed", test_no + 1);
          abort_run();
        end
        test_no++;
        run_test();
      end
    end
    $fclose(fd);
    if (test_no == 0) begin
      $display("test file holds no tests");
      abort_run();
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

//--- src.f
rtl/nec_ir_pkg.sv
rtl/ir_event_if.sv
rtl/ir_sampler.sv
rtl/edge_timer.sv
rtl/nec_frame_decoder.sv
rtl/nec_ir_receiver.sv
verification/nec_ir_tx_model.sv
verification/tb_nec_ir_receiver.sv

//--- Makefile
# Verilator build and run of the NEC IR receiver testbench
# Any variable can be set on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_nec_ir_receiver
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
PASS_TEXT ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/nec_ir_tests.txt
# pol rep_en tol(0 tight 1 normal 2 wide) kind(0 frame 1 repeat 2 repeat after idle)
# addr addr_n data data_n jitter | exp_strobe exp_repeat exp_addr exp_data
0 1 1 0 00 ff 16 e9 0 1 0 00 16
0 1 1 0 5a a5 3c c3 0 1 0 5a 3c
0 1 1 1 00 00 00 00 0 1 1 5a 3c
0 0 1 1 00 00 00 00 0 0 0 00 00
0 1 1 2 00 00 00 00 0 0 0 00 00
# Complement errors
0 1 1 0 5a a4 3c c3 0 0 0 00 00
0 1 1 0 5a a5 3c c2 0 0 0 00 00
# Inverted line
1 1 1 0 5a a5 3c c3 0 1 0 5a 3c
1 1 1 1 00 00 00 00 0 1 1 5a 3c
# Space jitter against the tolerance windows
0 1 1 0 12 ed 34 cb 1 1 0 12 34
0 1 2 0 12 ed 34 cb 1 1 0 12 34
0 1 2 0 ab 54 cd 32 3 1 0 ab cd
0 1 0 0 12 ed 34 cb 3 0 0 00 00
0 1 0 0 12 ed 34 cb 1 0 0 00 00
0 1 1 0 12 ed 34 cb 3 0 0 00 00
0 1 0 0 c4 3b 7e 81 0 1 0 c4 7e
